// ==== verilog/line_render_pkg.sv ====
package line_render_pkg;

    // Line geometry.
    localparam int line_len   = 256;
    localparam int idx_w      = 8;

    // Row format from the fetch unit.
    localparam int pix_w      = 4;
    localparam int row_pixels = 8;
    localparam int row_w      = pix_w * row_pixels;

    // Line buffer entry. A color of zero is transparent.
    typedef struct packed {
        logic             palette;
        logic [pix_w-1:0] color;
    } pixel_t;

    // Attribute store entry, valid only while tag matches the render bank.
    typedef struct packed {
        logic tag;
        logic is_sprite;
        logic prio;
    } attr_t;

    // One row to draw. Pixel 0 sits in the top nibble of data.
    typedef struct packed {
        logic [idx_w-1:0] idx;
        logic [row_w-1:0] data;
        logic             is_sprite;
        logic             hflip;
        logic             palette;
        logic             prio;
    } render_cmd_t;

    // Write into the render bank.
    typedef struct packed {
        logic             en;
        logic [idx_w-1:0] idx;
        pixel_t           pixel;
    } line_wr_t;

endpackage

// ==== verilog/line_ram.sv ====
`timescale 1ns/1ps

module line_ram import line_render_pkg::*; #(
    parameter type entry_t = logic
) (
    input  logic             clk,
    input  logic             wr_en,
    input  logic [idx_w-1:0] wr_idx,
    input  entry_t           wr_data,
    input  logic [idx_w-1:0] rd_idx,
    output entry_t           rd_data
);

    entry_t mem [line_len];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // Reads see the old entry when the same index is written this cycle.
    assign rd_data = mem[rd_idx];

endmodule

// ==== verilog/renderer.sv ====
`timescale 1ns/1ps

module renderer import line_render_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        render_start,
    input  render_cmd_t cmd,
    input  logic        line_tag,
    output logic        busy,
    output logic        last_pixel,
    output line_wr_t    line_wr
);

    // Row state.
    render_cmd_t      cmd_r;
    render_cmd_t      cmd_next;
    logic [2:0]       cnt_r;
    logic [2:0]       cnt_next;
    logic             busy_r;
    logic             busy_next;
    logic             last_r;
    logic             last_next;

    // Registered line buffer write.
    logic             wr_en_r;
    logic             wr_en_next;
    logic [idx_w-1:0] wr_idx_r;
    logic [idx_w-1:0] wr_idx_next;
    pixel_t           wr_pixel_r;
    pixel_t           wr_pixel_next;

    logic             draw;
    logic [2:0]       nibble_sel;
    logic [pix_w-1:0] pixel_data;
    logic             suppress;

    attr_t            attr_rd;
    attr_t            attr_wr;
    logic             attr_valid;

    assign busy       = busy_r;
    assign last_pixel = last_r;
    assign line_wr    = '{en: wr_en_r, idx: wr_idx_r, pixel: wr_pixel_r};

    // Sequencing of the eight pixels.
    always_comb begin
        cmd_next    = cmd_r;
        cnt_next    = cnt_r;
        busy_next   = busy_r;
        last_next   = 1'b0;
        wr_idx_next = wr_idx_r;
        draw        = 1'b0;

        if (render_start) begin
            cmd_next    = cmd;
            cnt_next    = '0;
            busy_next   = 1'b1;
            wr_idx_next = cmd.idx;
            draw        = 1'b1;
        end else if (busy_r) begin
            if (cnt_r == 3'(row_pixels - 1)) begin
                busy_next = 1'b0;
            end else begin
                cnt_next    = cnt_r + 3'd1;
                wr_idx_next = wr_idx_r + idx_w'(1);
                draw        = 1'b1;
                last_next   = (cnt_r == 3'(row_pixels - 2));
            end
        end
    end

    // Flip reverses the nibble order within the row.
    always_comb begin
        nibble_sel = cmd_next.hflip ? ~cnt_next : cnt_next;
        pixel_data = cmd_next.data[pix_w * (row_pixels - 1 - int'(nibble_sel)) +: pix_w];
    end

    // Attribute store, written in the cycle the decision is made so the
    // next pixel always sees it.
    line_ram #(
        .entry_t (attr_t)
    ) u_attr_ram (
        .clk     (clk),
        .wr_en   (wr_en_next),
        .wr_idx  (wr_idx_next),
        .wr_data (attr_wr),
        .rd_idx  (wr_idx_next),
        .rd_data (attr_rd)
    );

    // Entries left from the other bank read as empty.
    assign attr_valid = (attr_rd.tag == line_tag);

    always_comb begin
        suppress = 1'b0;
        if (cmd_next.is_sprite) begin
            // Transparent, behind an earlier sprite, or under a priority tile.
            suppress = (pixel_data == '0)
                    || (attr_valid && attr_rd.is_sprite)
                    || (attr_valid && attr_rd.prio && !cmd_next.prio);
        end

        wr_en_next            = draw && !suppress;
        wr_pixel_next.palette = cmd_next.palette;
        wr_pixel_next.color   = pixel_data;

        attr_wr.tag       = line_tag;
        attr_wr.is_sprite = cmd_next.is_sprite;
        attr_wr.prio      = cmd_next.prio && (pixel_data != '0);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_r   <= '0;
            busy_r  <= 1'b0;
            last_r  <= 1'b0;
            wr_en_r <= 1'b0;
        end else begin
            cnt_r   <= cnt_next;
            busy_r  <= busy_next;
            last_r  <= last_next;
            wr_en_r <= wr_en_next;
        end
    end

    always_ff @(posedge clk) begin
        cmd_r      <= cmd_next;
        wr_idx_r   <= wr_idx_next;
        wr_pixel_r <= wr_pixel_next;
    end

    // Writes reach the line buffer only while a row is in flight.
    assert property (@(posedge clk) disable iff (reset)
        line_wr.en |-> busy)
        else $error("renderer: line write outside a busy row");

    // The row ends after its last pixel unless a new row was started.
    assert property (@(posedge clk) disable iff (reset)
        last_pixel && !render_start |=> !busy)
        else $error("renderer: busy held past last pixel");

endmodule

// ==== verilog/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer import line_render_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  line_wr_t         line_wr,
    input  logic             line_swap,
    input  logic             scan_en,
    input  logic [idx_w-1:0] scan_idx,
    output logic             line_tag,
    output pixel_t           scan_pixel,
    output logic             scan_valid
);

    logic   bank_r;
    logic   scan_bank;
    pixel_t bank_rd_data [2];
    pixel_t scan_pixel_r;
    logic   scan_valid_r;

    assign scan_bank  = ~bank_r;
    assign line_tag   = bank_r;
    assign scan_pixel = scan_pixel_r;
    assign scan_valid = scan_valid_r;

    // The render bank takes line writes, the scan bank is cleared behind each read.
    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic draw_bank;

        assign draw_bank = (bank_r == 1'(b));

        line_ram #(
            .entry_t (pixel_t)
        ) u_bank (
            .clk     (clk),
            .wr_en   (draw_bank ? line_wr.en : scan_en),
            .wr_idx  (draw_bank ? line_wr.idx : scan_idx),
            .wr_data (draw_bank ? line_wr.pixel : pixel_t'('0)),
            .rd_idx  (scan_idx),
            .rd_data (bank_rd_data[b])
        );
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_r       <= 1'b0;
            scan_valid_r <= 1'b0;
        end else begin
            if (line_swap) begin
                bank_r <= ~bank_r;
            end
            scan_valid_r <= scan_en;
        end
    end

    // Read value before the clear lands.
    always_ff @(posedge clk) begin
        if (scan_en) begin
            scan_pixel_r <= bank_rd_data[scan_bank];
        end
    end

    // A swap during a row would split it across both banks.
    assert property (@(posedge clk) disable iff (reset)
        !(line_swap && line_wr.en))
        else $error("line_buffer: line swap while a row is being drawn");

endmodule

// ==== verilog/line_render_top.sv ====
`timescale 1ns/1ps

module line_render_top import line_render_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             render_start,
    input  render_cmd_t      cmd,
    output logic             busy,
    output logic             last_pixel,
    input  logic             line_swap,
    input  logic             scan_en,
    input  logic [idx_w-1:0] scan_idx,
    output pixel_t           scan_pixel,
    output logic             scan_valid
);

    line_wr_t line_wr;
    logic     line_tag;

    // Draws rows into the current render bank.
    renderer u_renderer (
        .clk          (clk),
        .reset        (reset),
        .render_start (render_start),
        .cmd          (cmd),
        .line_tag     (line_tag),
        .busy         (busy),
        .last_pixel   (last_pixel),
        .line_wr      (line_wr)
    );

    // Double buffered line, scanned out from the other bank.
    line_buffer u_line_buffer (
        .clk        (clk),
        .reset      (reset),
        .line_wr    (line_wr),
        .line_swap  (line_swap),
        .scan_en    (scan_en),
        .scan_idx   (scan_idx),
        .line_tag   (line_tag),
        .scan_pixel (scan_pixel),
        .scan_valid (scan_valid)
    );

endmodule

// ==== bench/line_render_tb.sv ====
`timescale 1ns/1ps

module line_render_tb import line_render_pkg::*; ();

    logic             clk;
    logic             reset;
    logic             render_start;
    render_cmd_t      cmd;
    logic             busy;
    logic             last_pixel;
    logic             line_swap;
    logic             scan_en;
    logic [idx_w-1:0] scan_idx;
    pixel_t           scan_pixel;
    logic             scan_valid;
    logic             loaded;

    // One entry per stim command.
    byte              op_q[$];
    render_cmd_t      cmd_q[$];
    logic [idx_w-1:0] idx_q[$];
    pixel_t           pix_q[$];
    string            name_q[$];

    line_render_top u_line_render_top (
        .clk          (clk),
        .reset        (reset),
        .render_start (render_start),
        .cmd          (cmd),
        .busy         (busy),
        .last_pixel   (last_pixel),
        .line_swap    (line_swap),
        .scan_en      (scan_en),
        .scan_idx     (scan_idx),
        .scan_pixel   (scan_pixel),
        .scan_valid   (scan_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_bit(input string name, input string sig, input logic exp,
                             input logic act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s %s: expected %0b actual %0b",
                                     name, sig, exp, act));
        end
    endtask

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s scan_pixel: expected %h actual %h",
                                     name, exp, act));
        end
    endtask

    // Inputs change shortly after the rising edge.
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic load_stim();
        int               fd;
        int               n;
        string            line;
        string            op;
        string            name;
        logic [idx_w-1:0] idx;
        logic [row_w-1:0] data;
        logic             spr;
        logic             hf;
        logic             pal;
        logic             pr;
        logic [4:0]       pix;
        render_cmd_t      c;
        fd = $fopen("bench/line_render_stim.txt", "r");
        if (fd == 0) begin
            report_failure("could not open bench/line_render_stim.txt");
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s", op);
            if (n < 1 || op.getc(0) == "#") begin
                continue;
            end
            c = '0;
            idx = '0;
            pix = '0;
            if (op == "R") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %s",
                            op, idx, data, spr, hf, pal, pr, name);
                if (n != 8) begin
                    report_failure($sformatf("badly formed render line: %s", line));
                end
                c.idx       = idx;
                c.data      = data;
                c.is_sprite = spr;
                c.hflip     = hf;
                c.palette   = pal;
                c.prio      = pr;
            end else if (op == "W") begin
                n = $sscanf(line, "%s %s", op, name);
                if (n != 2) begin
                    report_failure($sformatf("badly formed swap line: %s", line));
                end
            end else if (op == "P") begin
                n = $sscanf(line, "%s %h %h %s", op, idx, pix, name);
                if (n != 4) begin
                    report_failure($sformatf("badly formed scan line: %s", line));
                end
            end else begin
                report_failure($sformatf("unknown command %s in stim file", op));
            end
            op_q.push_back(op.getc(0));
            cmd_q.push_back(c);
            idx_q.push_back(idx);
            pix_q.push_back(pixel_t'(pix));
            name_q.push_back(name);
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            report_failure("stim file holds no commands");
        end
    endtask

    // Pulse render_start and follow busy until the last pixel.
    task automatic render_row(input string name, input render_cmd_t c);
        int n;
        cmd = c;
        render_start = 1'b1;
        step();
        render_start = 1'b0;
        cmd = '0;
        n = 1;
        while (!last_pixel) begin
            check_bit(name, "busy", 1'b1, busy);
            if (n >= row_pixels) begin
                report_failure($sformatf("%s: last_pixel did not arrive within %0d cycles",
                                         name, row_pixels));
            end
            step();
            n++;
        end
        check_bit(name, "busy", 1'b1, busy);
        if (n != row_pixels) begin
            report_failure($sformatf("mismatch %s last_pixel cycle: expected %0d actual %0d",
                                     name, row_pixels, n));
        end
        step();
        check_bit(name, "busy", 1'b0, busy);
        check_bit(name, "last_pixel", 1'b0, last_pixel);
    endtask

    task automatic swap_banks();
        line_swap = 1'b1;
        step();
        line_swap = 1'b0;
    endtask

    task automatic scan_check(input string name, input logic [idx_w-1:0] idx,
                              input pixel_t exp);
        scan_en  = 1'b1;
        scan_idx = idx;
        step();
        scan_en  = 1'b0;
        check_bit(name, "scan_valid", 1'b1, scan_valid);
        check_pixel($sformatf("%s@%h", name, idx), exp, scan_pixel);
    endtask

    // Reads every position of the scan bank, leaving it cleared.
    task automatic clear_line();
        scan_en = 1'b1;
        for (int i = 0; i < line_len; i++) begin
            scan_idx = idx_w'(i);
            step();
        end
        scan_en = 1'b0;
    endtask

    initial begin
        loaded = 1'b0;
        wait (loaded);
        repeat (op_q.size() * 40 + 400) @(posedge clk);
        report_failure("timeout: the run did not finish within the watchdog limit");
    end

    initial begin
        reset        = 1'b1;
        render_start = 1'b0;
        cmd          = '0;
        line_swap    = 1'b0;
        scan_en      = 1'b0;
        scan_idx     = '0;
        load_stim();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        check_bit("reset", "busy", 1'b0, busy);
        check_bit("reset", "last_pixel", 1'b0, last_pixel);
        check_bit("reset", "scan_valid", 1'b0, scan_valid);

        // Both banks start undefined.
        clear_line();
        swap_banks();
        clear_line();
        swap_banks();

        for (int i = 0; i < op_q.size(); i++) begin
            if (op_q[i] == "R") begin
                render_row(name_q[i], cmd_q[i]);
            end else if (op_q[i] == "W") begin
                swap_banks();
            end else begin
                scan_check(name_q[i], idx_q[i], pix_q[i]);
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== bench/line_render_stim.txt ====
# R idx data sprite hflip palette prio name | W name | P idx expected_pixel name
# All values hex. A pixel is {palette, color}, so 15 is palette 1 color 5.
R 0a 12345678 0 0 1 0 tile_order
R 14 9abcdef1 0 1 0 0 tile_flip
R fc abcd1234 0 0 0 0 tile_wrap
R 1e 11111111 0 0 0 0 sprite_base
R 1e 20300400 1 0 1 0 sprite_clear
R 1e 56789abc 1 0 0 0 sprite_order
R 28 10203040 0 0 0 1 prio_tile
R 28 55555555 1 0 1 0 prio_behind
R 32 10203040 0 0 0 1 prio_tile2
R 32 66666666 1 0 1 1 prio_front
W swap_a
P 0a 11 tile_order
P 0b 12 tile_order
P 0c 13 tile_order
P 0d 14 tile_order
P 0e 15 tile_order
P 0f 16 tile_order
P 10 17 tile_order
P 11 18 tile_order
P 14 01 tile_flip
P 15 0f tile_flip
P 16 0e tile_flip
P 17 0d tile_flip
P 18 0c tile_flip
P 19 0b tile_flip
P 1a 0a tile_flip
P 1b 09 tile_flip
P fc 0a tile_wrap
P fd 0b tile_wrap
P fe 0c tile_wrap
P ff 0d tile_wrap
P 00 01 tile_wrap
P 01 02 tile_wrap
P 02 03 tile_wrap
P 03 04 tile_wrap
P 1e 12 sprite_order
P 1f 06 sprite_order
P 20 13 sprite_order
P 21 08 sprite_order
P 22 09 sprite_order
P 23 14 sprite_order
P 24 0b sprite_order
P 25 0c sprite_order
P 28 01 prio_behind
P 29 15 prio_behind
P 2a 02 prio_behind
P 2b 15 prio_behind
P 2c 03 prio_behind
P 2d 15 prio_behind
P 2e 04 prio_behind
P 2f 15 prio_behind
P 32 16 prio_front
P 33 16 prio_front
P 3c 00 empty_pos
P 0a 00 reread_a
P 1e 00 reread_a
P 28 00 reread_a
R 1e 77777777 1 0 0 0 stale_attr
W swap_b
P 1e 07 stale_attr
P 1f 07 stale_attr
P 25 07 stale_attr
P 1e 00 reread_b

// ==== line_render_top.f ====
verilog/line_render_pkg.sv
verilog/line_ram.sv
verilog/renderer.sv
verilog/line_buffer.sv
verilog/line_render_top.sv
bench/line_render_tb.sv

// ==== Makefile ====
# Verilator build for the line renderer.

TOP := line_render_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f line_render_top.f --top-module line_render_top

sim:
	verilator --binary --timing --assert -f line_render_top.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
